/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_dsp16_periph
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src/dsp16_defs.svh */
// DSP16 peripheral register map, field widths and parallel strobe timing
`ifndef DSP16_DEFS_SVH
`define DSP16_DEFS_SVH

// Word and select widths
`define DSP16_DATA_W        16
`define DSP16_SEL_W         3

// Register select codes seen on the host port
`define DSP16_SEL_PDX       0
`define DSP16_SEL_PIOC      1
`define DSP16_SEL_SDX       2

// PIOC bit positions
`define DSP16_PIOC_IRQ      0
`define DSP16_PIOC_BUSY     1
`define DSP16_PIOC_OBE      2
`define DSP16_PIOC_IEN      7

// Parallel strobe length in divided enable cycles
`define DSP16_STROBE_LEN    2

`endif

/* src/dsp16_periph.sv */
// DSP16 peripheral block with host register port, parallel and serial I/O
`timescale 1ns/10ps

module dsp16_periph (
    input  logic              clk,
    input  logic              rst,
    input  logic              clk_en,
    // Divided enable, also the clock output pin
    output logic              cen_cko,

    // Host register port
    input  dsp16_pkg::sel_t   reg_sel,
    input  logic              reg_wr,
    input  logic              reg_rd,
    input  dsp16_pkg::data_t  reg_wdata,
    output dsp16_pkg::data_t  reg_rdata,

    // Parallel I/O
    input  dsp16_pkg::data_t  pbus_in,
    output dsp16_pkg::data_t  pbus_out,
    output logic              pods_n,
    output logic              pids_n,
    output logic              psel,

    // Serial output
    input  logic              doen,
    output logic              sdo,
    output logic              ock,
    output logic              old,
    output logic              ose,
    output dsp16_pkg::data_t  ser_out,

    // Interrupt request
    input  logic              irq
);

    periph_bus_if pbus ();

    dsp16_regbus u_regbus (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .clk_en     ( clk_en    ),
        .cen_cko    ( cen_cko   ),
        .reg_sel    ( reg_sel   ),
        .reg_wr     ( reg_wr    ),
        .reg_rd     ( reg_rd    ),
        .reg_wdata  ( reg_wdata ),
        .reg_rdata  ( reg_rdata ),
        .bus        ( pbus.host )
    );

    dsp16_pio u_pio (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .bus        ( pbus.pio  ),
        .pbus_in    ( pbus_in   ),
        .pbus_out   ( pbus_out  ),
        .pods_n     ( pods_n    ),
        .pids_n     ( pids_n    ),
        .psel       ( psel      ),
        .irq        ( irq       )
    );

    dsp16_sio u_sio (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .bus        ( pbus.sio  ),
        .doen       ( doen      ),
        .sdo        ( sdo       ),
        .ock        ( ock       ),
        .old        ( old       ),
        .ose        ( ose       ),
        .ser_out    ( ser_out   )
    );

endmodule

/* src/dsp16_pio.sv */
// Parallel I/O port with strobe sequencer, data registers and interrupt latch
`timescale 1ns/10ps
`include "dsp16_defs.svh"

module dsp16_pio (
    input  logic              clk,
    input  logic              rst,

    periph_bus_if.pio         bus,

    // Parallel pins
    input  dsp16_pkg::data_t  pbus_in,
    output dsp16_pkg::data_t  pbus_out,
    output logic              pods_n,
    output logic              pids_n,
    output logic              psel,

    // External interrupt request
    input  logic              irq
);

    dsp16_pkg::pio_state_e  state;
    dsp16_pkg::strobe_cnt_t strobe_cnt;
    dsp16_pkg::data_t       pdx_in;
    logic                   pdx_hit;
    logic                   pioc_hit;
    logic                   busy;
    logic                   strobe_last;
    logic                   ien;
    logic                   pending;
    logic                   irq_q;
    logic                   irq_rise;

    assign pdx_hit  = bus.sel == dsp16_pkg::sel_t'(`DSP16_SEL_PDX);
    assign pioc_hit = bus.sel == dsp16_pkg::sel_t'(`DSP16_SEL_PIOC);
    assign busy     = state != dsp16_pkg::PIO_IDLE;

    // Final enable cycle of a running strobe
    assign strobe_last = busy && bus.cen && strobe_cnt == '0;

    // Strobe sequencer, PDX accesses while busy are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= dsp16_pkg::PIO_IDLE;
            strobe_cnt <= '0;
        end else begin
            case (state)
                dsp16_pkg::PIO_IDLE: begin
                    if (pdx_hit && bus.wr_stb) begin
                        state      <= dsp16_pkg::PIO_WRITE;
                        strobe_cnt <= dsp16_pkg::strobe_cnt_t'(`DSP16_STROBE_LEN - 1);
                    end else if (pdx_hit && bus.rd_stb) begin
                        state      <= dsp16_pkg::PIO_READ;
                        strobe_cnt <= dsp16_pkg::strobe_cnt_t'(`DSP16_STROBE_LEN - 1);
                    end
                end
                default: begin
                    if (strobe_last) begin
                        state <= dsp16_pkg::PIO_IDLE;
                    end else if (bus.cen) begin
                        strobe_cnt <= strobe_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // Output word and captured input word
    always_ff @(posedge clk) begin
        if (pdx_hit && bus.wr_stb && !busy) begin
            pbus_out <= bus.wdata;
        end
        if (strobe_last && state == dsp16_pkg::PIO_READ) begin
            pdx_in <= pbus_in;
        end
    end

    assign pods_n = state != dsp16_pkg::PIO_WRITE;
    assign pids_n = state != dsp16_pkg::PIO_READ;
    // Only one peripheral on this port
    assign psel   = 1'b0;

    // irq edge seen on enable cycles only
    assign irq_rise = bus.cen && irq && !irq_q && ien;

    always_ff @(posedge clk) begin
        if (rst) begin
            ien     <= 1'b0;
            pending <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            if (bus.cen) begin
                irq_q <= irq;
            end
            if (pioc_hit && bus.wr_stb) begin
                ien <= bus.wdata[`DSP16_PIOC_IEN];
                // Write one to clear
                if (bus.wdata[`DSP16_PIOC_IRQ]) begin
                    pending <= 1'b0;
                end
            end
            // A new edge wins over a clear in the same cycle
            if (irq_rise) begin
                pending <= 1'b1;
            end
        end
    end

    assign bus.pio_rdata  = pdx_in;
    assign bus.pio_status = {ien, busy, pending};

    // Output word only moves as a new output strobe starts
    a_pbus_out_hold: assert property (@(posedge clk) disable iff (rst)
        $changed(pbus_out) |-> $fell(pods_n))
        else $error("pbus_out changed outside the start of an output strobe");

    a_pods_len: assert property (@(posedge clk) disable iff (rst)
        $fell(pods_n) |-> (!pods_n throughout bus.cen [-> `DSP16_STROBE_LEN]) ##1 pods_n)
        else $error("pods_n strobe length wrong");

    a_pids_len: assert property (@(posedge clk) disable iff (rst)
        $fell(pids_n) |-> (!pids_n throughout bus.cen [-> `DSP16_STROBE_LEN]) ##1 pids_n)
        else $error("pids_n strobe length wrong");

endmodule

/* src/dsp16_pkg.sv */
// DSP16 peripheral types shared by the register bus and both ports
`include "dsp16_defs.svh"

package dsp16_pkg;

    // Peripheral data word and host register select
    typedef logic [`DSP16_DATA_W-1:0] data_t;
    typedef logic [`DSP16_SEL_W-1:0]  sel_t;

    // Serial bits still to send, must hold a full word count
    typedef logic [$clog2(`DSP16_DATA_W+1)-1:0] bit_cnt_t;

    // Enable cycles left in a parallel strobe
    typedef logic [$clog2(`DSP16_STROBE_LEN+1)-1:0] strobe_cnt_t;

    // Parallel port sequencer
    typedef enum logic [1:0] {
        PIO_IDLE,
        PIO_WRITE,
        PIO_READ
    } pio_state_e;

    // Serial output shifter
    typedef enum logic {
        SIO_IDLE,
        SIO_SHIFT
    } sio_state_e;

endpackage

/* src/dsp16_regbus.sv */
// Host register port decoder with clock-enable divider and read-data mux
`timescale 1ns/10ps
`include "dsp16_defs.svh"

module dsp16_regbus (
    input  logic              clk,
    input  logic              rst,
    input  logic              clk_en,
    output logic              cen_cko,

    // Host register port
    input  dsp16_pkg::sel_t   reg_sel,
    input  logic              reg_wr,
    input  logic              reg_rd,
    input  dsp16_pkg::data_t  reg_wdata,
    output dsp16_pkg::data_t  reg_rdata,

    periph_bus_if.host        bus
);

    logic             cen_phase;
    dsp16_pkg::data_t pioc_view;

    // Divide the input enable by two
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_phase <= 1'b0;
        end else if (clk_en) begin
            cen_phase <= ~cen_phase;
        end
    end

    assign bus.cen  = clk_en & cen_phase;
    assign cen_cko  = bus.cen;

    // Accesses only count on divided enable cycles
    assign bus.wr_stb = bus.cen & reg_wr;
    assign bus.rd_stb = bus.cen & reg_rd;
    assign bus.sel    = reg_sel;
    assign bus.wdata  = reg_wdata;

    // PIOC status word
    always_comb begin
        pioc_view                   = '0;
        pioc_view[`DSP16_PIOC_IRQ]  = bus.pio_status[0];
        pioc_view[`DSP16_PIOC_BUSY] = bus.pio_status[1];
        pioc_view[`DSP16_PIOC_OBE]  = bus.obe;
        pioc_view[`DSP16_PIOC_IEN]  = bus.pio_status[2];
    end

    // Combinational view of the selected register
    always_comb begin
        case (reg_sel)
            dsp16_pkg::sel_t'(`DSP16_SEL_PDX):  reg_rdata = bus.pio_rdata;
            dsp16_pkg::sel_t'(`DSP16_SEL_PIOC): reg_rdata = pioc_view;
            dsp16_pkg::sel_t'(`DSP16_SEL_SDX):  reg_rdata = bus.sio_rdata;
            // Unmapped selects read as zero
            default:                            reg_rdata = '0;
        endcase
    end

endmodule

/* src/dsp16_sio.sv */
// Serial output port with double buffer, MSB-first shifter and output clock
`timescale 1ns/10ps
`include "dsp16_defs.svh"

module dsp16_sio (
    input  logic              clk,
    input  logic              rst,

    periph_bus_if.sio         bus,

    // Serial pins
    input  logic              doen,
    output logic              sdo,
    output logic              ock,
    output logic              old,
    output logic              ose,
    output dsp16_pkg::data_t  ser_out
);

    dsp16_pkg::sio_state_e  state;
    dsp16_pkg::bit_cnt_t    bits_left;
    dsp16_pkg::data_t       sdx_buf;
    dsp16_pkg::data_t       shift_reg;
    logic                   obe_q;
    logic                   sdx_wr;
    logic                   load;
    logic                   shift_en;

    // Writes into a full buffer are dropped
    assign sdx_wr = bus.wr_stb && obe_q &&
                    bus.sel == dsp16_pkg::sel_t'(`DSP16_SEL_SDX);

    // Buffer to shifter transfer on an idle enable cycle
    assign load = bus.cen && state == dsp16_pkg::SIO_IDLE && !obe_q;

    // Advance to the next bit at the end of the ock high phase
    assign shift_en = bus.cen && state == dsp16_pkg::SIO_SHIFT && ock;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= dsp16_pkg::SIO_IDLE;
            bits_left <= '0;
            obe_q     <= 1'b1;
            ock       <= 1'b0;
            old       <= 1'b0;
        end else begin
            // old spans the enable cycle after the transfer
            if (bus.cen) begin
                old <= load;
            end
            if (sdx_wr) begin
                obe_q <= 1'b0;
            end else if (load) begin
                obe_q <= 1'b1;
            end
            if (load) begin
                state     <= dsp16_pkg::SIO_SHIFT;
                bits_left <= dsp16_pkg::bit_cnt_t'(`DSP16_DATA_W);
                ock       <= 1'b0;
            end else if (bus.cen && state == dsp16_pkg::SIO_SHIFT) begin
                // Two enable cycles per bit, ock low then high
                ock <= ~ock;
                if (ock) begin
                    bits_left <= bits_left - 1'b1;
                    if (bits_left == dsp16_pkg::bit_cnt_t'(1)) begin
                        state <= dsp16_pkg::SIO_IDLE;
                    end
                end
            end
        end
    end

    // Buffer, shifter and parallel copy of the word in flight
    always_ff @(posedge clk) begin
        if (sdx_wr) begin
            sdx_buf <= bus.wdata;
        end
        if (load) begin
            shift_reg <= sdx_buf;
            ser_out   <= sdx_buf;
        end else if (shift_en) begin
            shift_reg <= {shift_reg[`DSP16_DATA_W-2:0], 1'b0};
        end
    end

    // MSB first, forced low while the output is disabled
    assign sdo = doen && state == dsp16_pkg::SIO_SHIFT && shift_reg[`DSP16_DATA_W-1];
    assign ose = state == dsp16_pkg::SIO_IDLE;

    assign bus.obe       = obe_q;
    assign bus.sio_rdata = sdx_buf;

    // One old pulse per transfer, never two transfers in a row
    a_old_one_cen: assert property (@(posedge clk) disable iff (rst)
        (old && bus.cen) |=> !old)
        else $error("old held past one enable cycle");

    a_sdo_stable: assert property (@(posedge clk) disable iff (rst)
        (ock && $stable(doen)) |-> $stable(sdo))
        else $error("sdo changed while ock high");

endmodule

/* src/periph_bus_if.sv */
// Register bus from the host decoder to the parallel and serial ports
`timescale 1ns/10ps

interface periph_bus_if;

    // Divided clock enable, runs all peripheral logic
    logic               cen;

    // One-clock access strobes, only high together with cen
    dsp16_pkg::sel_t    sel;
    logic               wr_stb;
    logic               rd_stb;
    dsp16_pkg::data_t   wdata;

    // Parallel port read data and status
    // pio_status is {ien, busy, pending}
    dsp16_pkg::data_t   pio_rdata;
    logic [2:0]         pio_status;

    // Serial port read data and buffer empty flag
    dsp16_pkg::data_t   sio_rdata;
    logic               obe;

    modport host (
        output cen, sel, wr_stb, rd_stb, wdata,
        input  pio_rdata, pio_status, sio_rdata, obe
    );

    modport pio (
        input  cen, sel, wr_stb, rd_stb, wdata,
        output pio_rdata, pio_status
    );

    modport sio (
        input  cen, sel, wr_stb, wdata,
        output sio_rdata, obe
    );

endinterface

/* verif/tb_dsp16_periph.sv */
// Testbench for the DSP16 peripheral block, host port, parallel and serial I/O
`timescale 1ns/10ps
`include "dsp16_defs.svh"

module tb_dsp16_periph;

    // About 150 serial words of 64 clocks each, with margin
    localparam int CYCLE_LIMIT = 20000;

    logic              clk;
    logic              rst;
    logic              clk_en;
    logic              cen_cko;
    dsp16_pkg::sel_t   reg_sel;
    logic              reg_wr;
    logic              reg_rd;
    dsp16_pkg::data_t  reg_wdata;
    dsp16_pkg::data_t  reg_rdata;
    dsp16_pkg::data_t  pbus_in;
    dsp16_pkg::data_t  pbus_out;
    logic              pods_n;
    logic              pids_n;
    logic              psel;
    logic              doen;
    logic              sdo;
    logic              ock;
    logic              old;
    logic              ose;
    dsp16_pkg::data_t  ser_out;
    logic              irq;

    // Stimulus side model
    logic              rand_en = 1'b0;
    logic              en_phase = 1'b0;
    logic              cen_pred = 1'b0;
    logic              m_ien = 1'b0;
    logic              m_pending = 1'b0;
    int                words_sent = 0;
    int                old_count = 0;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;

    dsp16_pkg::data_t  pio_q[$];
    dsp16_pkg::data_t  word_q[$];
    dsp16_pkg::data_t  bits_q[$];
    dsp16_pkg::data_t  rx_q[$];

    // Monitor state
    int                strobe_clks = 0;
    int                strobe_cens = 0;
    logic              strobe_fixed = 1'b0;
    dsp16_pkg::data_t  strobe_word = '0;
    int                bit_n = 0;
    dsp16_pkg::data_t  rx_word = '0;
    logic              ock_prev = 1'b0;
    logic              old_prev = 1'b0;

    dsp16_periph uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input dsp16_pkg::data_t exp,
                         input dsp16_pkg::data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    // Expected PIOC read value from the model state
    function automatic dsp16_pkg::data_t pioc_ref(input logic ien, input logic pend,
                                                  input logic busy, input logic obe);
        dsp16_pkg::data_t v;
        v = '0;
        v[`DSP16_PIOC_IRQ]  = pend;
        v[`DSP16_PIOC_BUSY] = busy;
        v[`DSP16_PIOC_OBE]  = obe;
        v[`DSP16_PIOC_IEN]  = ien;
        return v;
    endfunction

    // Advance one clock, drive 2 ns after the edge, predict the divided enable
    task automatic next_cycle();
        @(posedge clk);
        #2;
        reg_wr   = 1'b0;
        reg_rd   = 1'b0;
        clk_en   = rand_en ? (($urandom % 4) != 0) : 1'b1;
        cen_pred = clk_en & en_phase;
        if (clk_en) begin
            en_phase = ~en_phase;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    // One host access in a cen_cko cycle, read data sampled mid-cycle
    task automatic host_access(input dsp16_pkg::sel_t sel, input logic wr, input logic rd,
                               input dsp16_pkg::data_t wdata, output dsp16_pkg::data_t rdata);
        next_cycle();
        while (!cen_pred) begin
            next_cycle();
        end
        reg_sel   = sel;
        reg_wr    = wr;
        reg_rd    = rd;
        reg_wdata = wdata;
        @(negedge clk);
        rdata = reg_rdata;
        next_cycle();
    endtask

    task automatic pdx_write(input dsp16_pkg::data_t w);
        dsp16_pkg::data_t v;
        pio_q.push_back(w);
        host_access(dsp16_pkg::sel_t'(`DSP16_SEL_PDX), 1'b1, 1'b0, w, v);
        while (!pods_n) begin
            next_cycle();
        end
    endtask

    task automatic pdx_read_check();
        dsp16_pkg::data_t v;
        dsp16_pkg::data_t exp_in;
        exp_in  = dsp16_pkg::data_t'($urandom);
        pbus_in = exp_in;
        host_access(dsp16_pkg::sel_t'(`DSP16_SEL_PDX), 1'b0, 1'b1, '0, v);
        host_access(dsp16_pkg::sel_t'(`DSP16_SEL_PIOC), 1'b0, 1'b1, '0, v);
        check("pioc during input strobe", pioc_ref(m_ien, m_pending, 1'b1, 1'b1), v);
        while (!pids_n) begin
            next_cycle();
        end
        // Pins move on, the captured word stays
        pbus_in = dsp16_pkg::data_t'($urandom);
        host_access(dsp16_pkg::sel_t'(`DSP16_SEL_PDX), 1'b0, 1'b0, '0, v);
        check("pdx read back", exp_in, v);
    endtask

    task automatic pioc_write(input dsp16_pkg::data_t w);
        dsp16_pkg::data_t v;
        host_access(dsp16_pkg::sel_t'(`DSP16_SEL_PIOC), 1'b1, 1'b0, w, v);
    endtask

    task automatic pioc_expect(input string name);
        dsp16_pkg::data_t v;
        host_access(dsp16_pkg::sel_t'(`DSP16_SEL_PIOC), 1'b0, 1'b1, '0, v);
        check(name, pioc_ref(m_ien, m_pending, 1'b0, 1'b1), v);
    endtask

    // Poll PIOC until the buffer is empty, then write SDX
    task automatic sdx_send(input dsp16_pkg::data_t w);
        dsp16_pkg::data_t st;
        st = '0;
        while (!st[`DSP16_PIOC_OBE]) begin
            host_access(dsp16_pkg::sel_t'(`DSP16_SEL_PIOC), 1'b0, 1'b1, '0, st);
        end
        word_q.push_back(w);
        bits_q.push_back(doen ? w : '0);
        host_access(dsp16_pkg::sel_t'(`DSP16_SEL_SDX), 1'b1, 1'b0, w, st);
        words_sent++;
    endtask

    task automatic wait_serial_idle();
        dsp16_pkg::data_t st;
        st = '0;
        while (!st[`DSP16_PIOC_OBE]) begin
            host_access(dsp16_pkg::sel_t'(`DSP16_SEL_PIOC), 1'b0, 1'b1, '0, st);
        end
        while (!ose) begin
            next_cycle();
        end
    endtask

    initial begin
        dsp16_pkg::data_t v;
        void'($urandom(32'ha410));
        rst       = 1'b1;
        clk_en    = 1'b0;
        reg_sel   = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_wdata = '0;
        pbus_in   = '0;
        doen      = 1'b1;
        irq       = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // Pin levels out of reset, {pods_n, pids_n, old, ock, ose, cen_cko}
        check("pins after reset", dsp16_pkg::data_t'(6'b110010),
              dsp16_pkg::data_t'({pods_n, pids_n, old, ock, ose, cen_cko}));
        pioc_expect("pioc after reset");

        repeat (5) pdx_write(dsp16_pkg::data_t'($urandom));
        repeat (3) pdx_read_check();

        repeat (6) sdx_send(dsp16_pkg::data_t'($urandom));
        wait_serial_idle();
        doen = 1'b0;
        sdx_send(dsp16_pkg::data_t'($urandom));
        wait_serial_idle();
        doen = 1'b1;

        // Second word waits in the buffer, a third write is dropped
        sdx_send(dsp16_pkg::data_t'($urandom));
        sdx_send(dsp16_pkg::data_t'($urandom));
        host_access(dsp16_pkg::sel_t'(`DSP16_SEL_PIOC), 1'b0, 1'b1, '0, v);
        check("obe with full buffer", '0, dsp16_pkg::data_t'(v[`DSP16_PIOC_OBE]));
        host_access(dsp16_pkg::sel_t'(`DSP16_SEL_SDX), 1'b1, 1'b0, 16'hdead, v);
        wait_serial_idle();

        // Interrupt latch
        pioc_write('0);
        irq = 1'b1;
        idle(6);
        pioc_expect("irq edge while disabled");
        irq = 1'b0;
        idle(6);
        pioc_write(16'h0080);
        m_ien = 1'b1;
        pioc_expect("irq enabled");
        irq = 1'b1;
        idle(6);
        m_pending = 1'b1;
        pioc_expect("irq edge while enabled");
        irq = 1'b0;
        idle(4);
        pioc_write(16'h0081);
        m_pending = 1'b0;
        pioc_expect("irq cleared");

        rand_en = 1'b1;
        repeat (4) pdx_write(dsp16_pkg::data_t'($urandom));
        repeat (4) sdx_send(dsp16_pkg::data_t'($urandom));
        wait_serial_idle();
        rand_en = 1'b0;
        idle(8);

        check("serial words left", '0, dsp16_pkg::data_t'(bits_q.size()));
        check("parallel words left", '0, dsp16_pkg::data_t'(pio_q.size()));
        check("old pulses", dsp16_pkg::data_t'(words_sent), dsp16_pkg::data_t'(old_count));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Divided enable against the prediction
    always @(negedge clk) begin
        check("cen_cko", dsp16_pkg::data_t'(cen_pred), dsp16_pkg::data_t'(cen_cko));
    end

    // Parallel output strobes, word and length
    always @(negedge clk) begin
        if (!pods_n) begin
            if (strobe_clks == 0) begin
                strobe_fixed = !rand_en;
                if (pio_q.size() == 0) begin
                    report_error("pods_n strobe with no write pending");
                end else begin
                    strobe_word = pio_q.pop_front();
                end
            end
            check("pbus_out during strobe", strobe_word, pbus_out);
            check("psel during strobe", '0, dsp16_pkg::data_t'(psel));
            strobe_clks++;
            if (cen_cko) begin
                strobe_cens++;
            end
        end else if (strobe_clks != 0) begin
            if (strobe_fixed) begin
                check("pods_n clocks", 16'd4, dsp16_pkg::data_t'(strobe_clks));
            end
            check("pods_n enable cycles", dsp16_pkg::data_t'(`DSP16_STROBE_LEN),
                  dsp16_pkg::data_t'(strobe_cens));
            strobe_clks = 0;
            strobe_cens = 0;
        end
    end

    // Serial monitor, one bit per rising ock
    always @(negedge clk) begin
        if (old && !old_prev) begin
            old_count++;
            bit_n = 0;
            if (word_q.size() == 0) begin
                report_error("old pulse with no serial word pending");
            end else begin
                check("ser_out at old", word_q.pop_front(), ser_out);
            end
        end
        if (ock && !ock_prev) begin
            rx_word = {rx_word[`DSP16_DATA_W-2:0], sdo};
            bit_n++;
            if (bit_n == `DSP16_DATA_W) begin
                rx_q.push_back(rx_word);
                bit_n = 0;
            end
        end
        if (!doen && sdo) begin
            report_error("sdo high while doen is low");
        end
        old_prev = old;
        ock_prev = ock;
    end

    // Rebuilt words against the model, in order
    always @(posedge clk) begin
        dsp16_pkg::data_t got;
        while (rx_q.size() != 0) begin
            got = rx_q.pop_front();
            if (bits_q.size() == 0) begin
                report_error("serial word received with none expected");
            end else begin
                check("serial word", bits_q.pop_front(), got);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: test did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+src
src/dsp16_pkg.sv
src/periph_bus_if.sv
src/dsp16_regbus.sv
src/dsp16_pio.sv
src/dsp16_sio.sv
src/dsp16_periph.sv
verif/tb_dsp16_periph.sv
